/* src/core_macros.svh */
// Size and latency settings of the execute and write-back core, included by RTL and testbench
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Number of architectural registers
`define CORE_NREGS 16

// Number of 32-bit words in the data memory
`define CORE_DMEM_WORDS 32

// Wait cycles before load data or a store acknowledge
`define CORE_LSU_WAIT 2

`endif

/* src/core_pkg.sv */
// Shared types of the execute and write-back core, imported by every RTL module
`include "core_macros.svh"

package core_pkg;

  // Register index
  typedef logic [$clog2(`CORE_NREGS)-1:0] rf_addr_t;

  // Supported operations
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_LI,
    OP_LW,
    OP_SW
  } opcode_e;

  // Result of the address protection check
  typedef enum logic {
    MPU_OK,
    MPU_ERR
  } mpu_status_e;

  // Controller states
  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_EXEC,
    CTRL_WB,
    CTRL_LSU_WAIT
  } ctrl_state_e;

  // Incoming instruction word
  typedef struct packed {
    opcode_e     op;
    rf_addr_t    rd;
    rf_addr_t    rs1;
    rf_addr_t    rs2;
    logic [15:0] imm;
  } instr_t;

  // EX/WB pipeline register
  typedef struct packed {
    logic        instr_valid;
    logic        rf_we;
    rf_addr_t    rf_waddr;
    logic [31:0] rf_wdata;    // ALU result or memory address
    logic        lsu_en;
    logic        lsu_we;
    logic [31:0] lsu_wdata;
  } ex_wb_pipe_t;

  // Controller outputs to the stages
  typedef struct packed {
    logic issue;
    logic halt_wb;
    logic kill_wb;
  } ctrl_fsm_t;

endpackage

/* src/ctrl_fsm.sv */
// Controller FSM that serializes instructions, waits on the LSU and kills write-back on a flush
`timescale 1ns/1ps

module ctrl_fsm import core_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  input  logic      instr_valid_i,
  input  logic      flush_i,
  input  logic      lsu_en_i,
  input  logic      wb_valid_i,
  input  logic      lsu_fault_i,
  output logic      instr_ready_o,
  output ctrl_fsm_t ctrl_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        in_wb;

  // Only one instruction in flight, so accept only when idle
  assign instr_ready_o = (state_q == CTRL_IDLE);

  // Write-back is active in both WB states
  assign in_wb = (state_q == CTRL_WB) || (state_q == CTRL_LSU_WAIT);

  assign ctrl_o.issue   = instr_valid_i && instr_ready_o;
  // Nothing in write-back while idle
  assign ctrl_o.halt_wb = (state_q == CTRL_IDLE);
  // Flush kills the instruction in the same cycle
  assign ctrl_o.kill_wb = flush_i && in_wb;

  ////////////////////////////////////////////////////////////////////////////
  // Next state

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE: begin
        // Transfer edge loads the EX/WB pipe
        if (ctrl_o.issue) begin
          state_d = CTRL_WB;
        end
      end
      CTRL_WB: begin
        // ALU result and faults finish in the first write-back cycle
        if (ctrl_o.kill_wb || wb_valid_i || lsu_fault_i) begin
          state_d = CTRL_IDLE;
        end else if (lsu_en_i) begin
          state_d = CTRL_LSU_WAIT;
        end
      end
      CTRL_LSU_WAIT: begin
        // Hold until the LSU answers or the instruction is flushed
        if (ctrl_o.kill_wb || wb_valid_i || lsu_fault_i) begin
          state_d = CTRL_IDLE;
        end
      end
      default: begin
        state_d = CTRL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* src/ex_unit.sv */
// Execute unit computing ALU results and memory addresses into the EX/WB pipeline register
`timescale 1ns/1ps

module ex_unit import core_pkg::*; (
  input  logic        clk,
  input  logic        reset_i,
  input  logic        issue_i,
  input  logic        kill_i,
  input  instr_t      instr_i,
  input  logic [31:0] rs1_data_i,
  input  logic [31:0] rs2_data_i,
  output rf_addr_t    rs1_addr_o,
  output rf_addr_t    rs2_addr_o,
  output ex_wb_pipe_t pipe_o
);

  ex_wb_pipe_t pipe_q;
  logic [31:0] imm_sext;
  logic [31:0] result;
  logic        rf_we;
  logic        lsu_en;
  logic        lsu_we;

  // Operand fetch straight from the instruction fields
  assign rs1_addr_o = instr_i.rs1;
  assign rs2_addr_o = instr_i.rs2;

  assign imm_sext = {{16{instr_i.imm[15]}}, instr_i.imm};

  ////////////////////////////////////////////////////////////////////////////
  // Decode and ALU

  always_comb begin
    result = '0;
    rf_we  = 1'b0;
    lsu_en = 1'b0;
    lsu_we = 1'b0;
    case (instr_i.op)
      OP_ADD: begin
        result = rs1_data_i + rs2_data_i;
        rf_we  = 1'b1;
      end
      OP_SUB: begin
        result = rs1_data_i - rs2_data_i;
        rf_we  = 1'b1;
      end
      OP_XOR: begin
        result = rs1_data_i ^ rs2_data_i;
        rf_we  = 1'b1;
      end
      OP_LI: begin
        result = imm_sext;
        rf_we  = 1'b1;
      end
      OP_LW: begin
        // Word address of the load
        result = rs1_data_i + imm_sext;
        rf_we  = 1'b1;
        lsu_en = 1'b1;
      end
      OP_SW: begin
        result = rs1_data_i + imm_sext;
        lsu_en = 1'b1;
        lsu_we = 1'b1;
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // Issue wins over kill so back-to-back instructions are not lost
  always_ff @(posedge clk) begin
    if (reset_i) begin
      pipe_q <= '0;
    end else if (issue_i) begin
      pipe_q.instr_valid <= 1'b1;
      pipe_q.rf_we       <= rf_we;
      pipe_q.rf_waddr    <= instr_i.rd;
      pipe_q.rf_wdata    <= result;
      pipe_q.lsu_en      <= lsu_en;
      pipe_q.lsu_we      <= lsu_we;
      pipe_q.lsu_wdata   <= rs2_data_i;
    end else if (kill_i) begin
      pipe_q.instr_valid <= 1'b0;
    end
  end

  assign pipe_o = pipe_q;

endmodule

/* src/lsu_unit.sv */
// Load/store unit with a word-addressed data memory, fixed wait states and an address check
`timescale 1ns/1ps
`include "core_macros.svh"

module lsu_unit import core_pkg::*; (
  input  logic        clk,
  input  logic        reset_i,
  input  ex_wb_pipe_t pipe_i,
  input  logic        lsu_valid_i,
  output logic [31:0] lsu_rdata_o,
  output logic        lsu_valid_o,
  output mpu_status_e mpu_status_o
);

  localparam int unsigned AW = $clog2(`CORE_DMEM_WORDS);
  localparam int unsigned CW = $clog2(`CORE_LSU_WAIT + 1);

  logic [31:0]   mem_q [`CORE_DMEM_WORDS];
  logic          busy_q;
  logic          orphan_q;
  logic [CW-1:0] cnt_q;
  logic [AW-1:0] addr_q;
  logic          we_q;
  logic [31:0]   wdata_q;
  logic          addr_fault;
  logic          start;
  logic          done;

  ////////////////////////////////////////////////////////////////////////////
  // Protection check

  // Full 32-bit compare against the memory size
  assign addr_fault   = (pipe_i.rf_wdata >= 32'(`CORE_DMEM_WORDS));
  assign mpu_status_o = (lsu_valid_i && addr_fault) ? MPU_ERR : MPU_OK;

  // A faulting access never starts the counter
  assign start = lsu_valid_i && !addr_fault && !busy_q;
  assign done  = busy_q && (cnt_q == CW'(`CORE_LSU_WAIT));

  // No pulse for an access whose request went away
  assign lsu_valid_o = done && !orphan_q && lsu_valid_i;
  assign lsu_rdata_o = mem_q[addr_q];

  ////////////////////////////////////////////////////////////////////////////
  // Wait counter and memory

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_q   <= 1'b0;
      orphan_q <= 1'b0;
      cnt_q    <= '0;
      for (int i = 0; i < `CORE_DMEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (start) begin
      busy_q <= 1'b1;
      cnt_q  <= CW'(1);
    end else if (busy_q) begin
      if (done) begin
        busy_q   <= 1'b0;
        orphan_q <= 1'b0;
        // Memory side completes even after a flush
        if (we_q) begin
          mem_q[addr_q] <= wdata_q;
        end
      end else begin
        cnt_q <= cnt_q + CW'(1);
        // Flushed while waiting
        if (!lsu_valid_i) begin
          orphan_q <= 1'b1;
        end
      end
    end
  end

  // Access captured at start so a flush cannot change it
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q  <= pipe_i.rf_wdata[AW-1:0];
      we_q    <= pipe_i.lsu_we;
      wdata_q <= pipe_i.lsu_wdata;
    end
  end

endmodule

/* src/wb_stage.sv */
// Write-back stage selecting ALU or load data and producing the write, valid and stall flags
`timescale 1ns/1ps

module wb_stage import core_pkg::*; (
  input  ex_wb_pipe_t pipe_i,
  input  ctrl_fsm_t   ctrl_i,
  input  logic [31:0] lsu_rdata_i,
  input  logic        lsu_valid_i,
  input  mpu_status_e mpu_status_i,
  output logic        lsu_valid_o,
  output logic        rf_we_o,
  output rf_addr_t    rf_waddr_o,
  output logic [31:0] rf_wdata_o,
  output logic        wb_valid_o,
  output logic        data_stall_o,
  output logic        lsu_fault_o
);

  logic instr_valid;
  logic lsu_exception;
  logic lsu_done;

  // Live instruction in write-back
  assign instr_valid   = pipe_i.instr_valid && !ctrl_i.kill_wb && !ctrl_i.halt_wb;
  assign lsu_exception = (mpu_status_i != MPU_OK);

  // LSU instructions finish on the data pulse
  assign lsu_done = !pipe_i.lsu_en || lsu_valid_i;

  ////////////////////////////////////////////////////////////////////////////
  // Register file port

  // No write on a fault, on a kill or before load data arrives
  assign rf_we_o    = pipe_i.rf_we && instr_valid && !lsu_exception && lsu_done;
  assign rf_waddr_o = pipe_i.rf_waddr;
  assign rf_wdata_o = pipe_i.lsu_en ? lsu_rdata_i : pipe_i.rf_wdata;

  ////////////////////////////////////////////////////////////////////////////
  // LSU request and stage status

  // Not gated by kill so a started access runs to the end
  assign lsu_valid_o = pipe_i.lsu_en && pipe_i.instr_valid && !ctrl_i.halt_wb;

  assign wb_valid_o = (!pipe_i.lsu_en ||
                       (pipe_i.lsu_en && lsu_valid_i) ||
                       (pipe_i.lsu_en && lsu_exception)) && instr_valid;

  // Load or store still waiting on the LSU
  assign data_stall_o = pipe_i.lsu_en && instr_valid && !lsu_valid_i && !lsu_exception;

  assign lsu_fault_o = pipe_i.lsu_en && lsu_exception && instr_valid;

endmodule

/* src/regfile.sv */
// Register file with two combinational read ports and one write port, register 0 reads zero
`timescale 1ns/1ps
`include "core_macros.svh"

module regfile import core_pkg::*; (
  input  logic        clk,
  input  logic        reset_i,
  input  rf_addr_t    raddr_a_i,
  input  rf_addr_t    raddr_b_i,
  output logic [31:0] rdata_a_o,
  output logic [31:0] rdata_b_o,
  input  logic        we_i,
  input  rf_addr_t    waddr_i,
  input  logic [31:0] wdata_i
);

  logic [31:0] regs_q [`CORE_NREGS];

  // Register 0 is hardwired to zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

endmodule

/* src/core_top.sv */
// Top level of the execute and write-back core, the DUT seen by the testbench
`timescale 1ns/1ps

module core_top import core_pkg::*; (
  input  logic        clk,
  input  logic        reset_i,
  input  logic        instr_valid_i,
  input  instr_t      instr_i,
  input  logic        flush_i,
  output logic        instr_ready_o,
  output logic        rf_we_o,
  output rf_addr_t    rf_waddr_o,
  output logic [31:0] rf_wdata_o,
  output logic        wb_valid_o,
  output logic        data_stall_o,
  output logic        lsu_fault_o
);

  ctrl_fsm_t   ctrl;
  ex_wb_pipe_t ex_wb_pipe;
  rf_addr_t    rs1_addr;
  rf_addr_t    rs2_addr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] lsu_rdata;
  logic        lsu_valid;
  logic        lsu_req;
  mpu_status_e mpu_status;

  ctrl_fsm ctrl_fsm_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .instr_valid_i(instr_valid_i),
    .flush_i      (flush_i),
    .lsu_en_i     (ex_wb_pipe.lsu_en),
    .wb_valid_i   (wb_valid_o),
    .lsu_fault_i  (lsu_fault_o),
    .instr_ready_o(instr_ready_o),
    .ctrl_o       (ctrl)
  );

  // Pipe is dropped while the controller sits idle
  ex_unit ex_unit_inst (
    .clk       (clk),
    .reset_i   (reset_i),
    .issue_i   (ctrl.issue),
    .kill_i    (ctrl.halt_wb),
    .instr_i   (instr_i),
    .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data),
    .rs1_addr_o(rs1_addr),
    .rs2_addr_o(rs2_addr),
    .pipe_o    (ex_wb_pipe)
  );

  lsu_unit lsu_unit_inst (
    .clk         (clk),
    .reset_i     (reset_i),
    .pipe_i      (ex_wb_pipe),
    .lsu_valid_i (lsu_req),
    .lsu_rdata_o (lsu_rdata),
    .lsu_valid_o (lsu_valid),
    .mpu_status_o(mpu_status)
  );

  wb_stage wb_stage_inst (
    .pipe_i      (ex_wb_pipe),
    .ctrl_i      (ctrl),
    .lsu_rdata_i (lsu_rdata),
    .lsu_valid_i (lsu_valid),
    .mpu_status_i(mpu_status),
    .lsu_valid_o (lsu_req),
    .rf_we_o     (rf_we_o),
    .rf_waddr_o  (rf_waddr_o),
    .rf_wdata_o  (rf_wdata_o),
    .wb_valid_o  (wb_valid_o),
    .data_stall_o(data_stall_o),
    .lsu_fault_o (lsu_fault_o)
  );

  // Write port shared with the top outputs
  regfile regfile_inst (
    .clk      (clk),
    .reset_i  (reset_i),
    .raddr_a_i(rs1_addr),
    .raddr_b_i(rs2_addr),
    .rdata_a_o(rs1_data),
    .rdata_b_o(rs2_data),
    .we_i     (rf_we_o),
    .waddr_i  (rf_waddr_o),
    .wdata_i  (rf_wdata_o)
  );

endmodule

/* testbench/core_asserts.sv */
// Assertions on the write-back and handshake rules, bound into the core top level
`timescale 1ns/1ps

module core_asserts import core_pkg::*; (
  input logic      clk,
  input logic      reset_i,
  input ctrl_fsm_t ctrl_i,
  input logic      instr_ready_i,
  input logic      rf_we_i,
  input logic      wb_valid_i,
  input logic      data_stall_i,
  input logic      lsu_fault_i
);

  // Failures seen so far, watched by the testbench
  int unsigned error_count = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Write-back rules

  // Faulting access never writes a register
  assert property (@(posedge clk) disable iff (reset_i) lsu_fault_i |-> !rf_we_i)
    else begin
      error_count++;
      $error("register write during an LSU fault");
    end

  // Stall and completion are exclusive
  assert property (@(posedge clk) disable iff (reset_i) data_stall_i |-> !wb_valid_i)
    else begin
      error_count++;
      $error("write-back valid while stalled");
    end

  // One instruction in flight, so completion is a single pulse
  assert property (@(posedge clk) disable iff (reset_i) wb_valid_i |=> !wb_valid_i)
    else begin
      error_count++;
      $error("write-back valid for two cycles in a row");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Handshake

  // An issued or stalled instruction keeps the core busy in the next cycle
  assert property (@(posedge clk) disable iff (reset_i)
                   (ctrl_i.issue || data_stall_i) |=> !instr_ready_i)
    else begin
      error_count++;
      $error("instr_ready_o high while an instruction is in flight");
    end

endmodule

bind core_top core_asserts core_asserts_inst (
  .clk          (clk),
  .reset_i      (reset_i),
  .ctrl_i       (ctrl),
  .instr_ready_i(instr_ready_o),
  .rf_we_i      (rf_we_o),
  .wb_valid_i   (wb_valid_o),
  .data_stall_i (data_stall_o),
  .lsu_fault_i  (lsu_fault_o)
);

/* testbench/tb_core.sv */
// Testbench for the execute and write-back core, runs the instruction cases from the data file
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_core import core_pkg::*; ();

  // One instruction with the write-back result it should produce
  typedef struct packed {
    instr_t      instr;
    logic        flush;
    logic        exp_we;
    rf_addr_t    exp_waddr;
    logic [31:0] exp_wdata;
    logic        exp_fault;
  } case_t;

  logic        clk;
  logic        reset_i;
  logic        instr_valid_i;
  instr_t      instr_i;
  logic        flush_i;
  logic        instr_ready_o;
  logic        rf_we_o;
  rf_addr_t    rf_waddr_o;
  logic [31:0] rf_wdata_o;
  logic        wb_valid_o;
  logic        data_stall_o;
  logic        lsu_fault_o;

  case_t       cases[$];
  logic        cases_loaded = 1'b0;
  logic [7:0]  lfsr_q;
  int unsigned wb_count = 0;

  core_top core_top_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i),
    .flush_i      (flush_i),
    .instr_ready_o(instr_ready_o),
    .rf_we_o      (rf_we_o),
    .rf_waddr_o   (rf_waddr_o),
    .rf_wdata_o   (rf_wdata_o),
    .wb_valid_o   (wb_valid_o),
    .data_stall_o (data_stall_o),
    .lsu_fault_o  (lsu_fault_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // Galois LFSR, taps x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] state);
    logic [7:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 8'hB8;
    end
    return next;
  endfunction

  // Idle gap of 0 to 3 cycles, one LFSR step per bit
  task automatic take_gap(output int unsigned gap);
    gap = 0;
    for (int i = 0; i < 2; i++) begin
      gap    = (gap << 1) | lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic read_cases();
    int          fd;
    int          n;
    string       line;
    int unsigned f_op, f_rd, f_rs1, f_rs2, f_imm;
    int unsigned f_flush, f_we, f_waddr, f_wdata, f_fault;
    case_t       c;
    fd = $fopen("testbench/core_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file testbench/core_cases.txt");
      $display("Simulation failed");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Skip blank and comment lines
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f_op, f_rd, f_rs1, f_rs2,
                    f_imm, f_flush, f_we, f_waddr, f_wdata, f_fault);
        if (n == 10) begin
          c.instr.op  = opcode_e'(f_op[2:0]);
          c.instr.rd  = rf_addr_t'(f_rd);
          c.instr.rs1 = rf_addr_t'(f_rs1);
          c.instr.rs2 = rf_addr_t'(f_rs2);
          c.instr.imm = f_imm[15:0];
          c.flush     = f_flush[0];
          c.exp_we    = f_we[0];
          c.exp_waddr = rf_addr_t'(f_waddr);
          c.exp_wdata = f_wdata;
          c.exp_fault = f_fault[0];
          cases.push_back(c);
        end
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Driver and checker

  task automatic drive_cases();
    int unsigned gap;
    for (int k = 0; k < cases.size(); k++) begin
      take_gap(gap);
      repeat (gap) @(posedge clk);
      instr_valid_i <= 1'b1;
      instr_i       <= cases[k].instr;
      // Held stable until the core is ready
      @(negedge clk);
      while (!instr_ready_o) @(negedge clk);
      @(posedge clk);
      instr_valid_i <= 1'b0;
      // Flush lands in the first write-back cycle
      flush_i       <= cases[k].flush;
      @(posedge clk);
      flush_i <= 1'b0;
    end
  endtask

  task automatic check_case(input int idx, input case_t c);
    int unsigned lat;
    int unsigned exp_lat;
    logic        is_mem;
    logic        stall_seen;
    logic        done;
    lat        = 0;
    stall_seen = 1'b0;
    done       = 1'b0;
    is_mem     = (c.instr.op == OP_LW) || (c.instr.op == OP_SW);
    // Memory access waits, ALU ops and faults finish at once
    exp_lat = (is_mem && !c.exp_fault) ? `CORE_LSU_WAIT + 1 : 1;
    if (c.flush) begin
      exp_lat = 2;
    end
    while (!done) begin
      @(negedge clk);
      lat++;
      if (c.flush) begin
        if (instr_ready_o) begin
          done = 1'b1;
        end else begin
          check_value($sformatf("case %0d flushed wb_valid_o", idx), wb_valid_o, 0);
          check_value($sformatf("case %0d flushed rf_we_o", idx), rf_we_o, 0);
        end
      end else if (wb_valid_o) begin
        done = 1'b1;
      end else begin
        // Back-pressure while in flight
        check_value($sformatf("case %0d instr_ready_o", idx), instr_ready_o, 0);
        if (data_stall_o) begin
          stall_seen = 1'b1;
        end
      end
    end
    check_value($sformatf("case %0d latency", idx), lat, exp_lat);
    if (!c.flush) begin
      check_value($sformatf("case %0d rf_we_o", idx), rf_we_o, c.exp_we);
      check_value($sformatf("case %0d lsu_fault_o", idx), lsu_fault_o, c.exp_fault);
      if (c.exp_we) begin
        check_value($sformatf("case %0d rf_waddr_o", idx), rf_waddr_o, c.exp_waddr);
        check_value($sformatf("case %0d rf_wdata_o", idx), rf_wdata_o, c.exp_wdata);
      end
      if (is_mem && !c.exp_fault) begin
        check_value($sformatf("case %0d data_stall_o seen", idx), stall_seen, 1);
      end
    end
  endtask

  task automatic check_cases();
    @(negedge clk);
    for (int k = 0; k < cases.size(); k++) begin
      // Handshake seen half a cycle before the transfer edge
      while (!(instr_valid_i && instr_ready_o)) @(negedge clk);
      check_case(k, cases[k]);
    end
  endtask

  // Every write-back pulse, to catch double execution
  always @(negedge clk) begin
    if (!reset_i && wb_valid_o) begin
      wb_count++;
    end
  end

  // A failed bound assertion ends the run at once
  always @(core_top_inst.core_asserts_inst.error_count) begin
    if (core_top_inst.core_asserts_inst.error_count != 0) begin
      $display("An assertion in the core checker failed");
      $display("Simulation failed");
      $fatal(1);
    end
  end

  // Each case gets the longest LSU latency plus slack
  initial begin : watchdog
    wait (cases_loaded);
    repeat (4 + cases.size() * (`CORE_LSU_WAIT + 8)) @(posedge clk);
    $display("Timeout: the core stopped completing instructions");
    $display("Simulation failed");
    $fatal(1);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin : main
    int unsigned exp_pulses;
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    flush_i       = 1'b0;
    lfsr_q        = 8'd72;
    read_cases();
    check_value("number of cases read", (cases.size() > 0), 1);
    cases_loaded = 1'b1;
    repeat (3) @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    check_value("instr_ready_o after reset", instr_ready_o, 1);
    check_value("rf_we_o after reset", rf_we_o, 0);
    check_value("rf_waddr_o after reset", rf_waddr_o, 0);
    check_value("rf_wdata_o after reset", rf_wdata_o, 0);
    check_value("wb_valid_o after reset", wb_valid_o, 0);
    check_value("data_stall_o after reset", data_stall_o, 0);
    check_value("lsu_fault_o after reset", lsu_fault_o, 0);
    @(posedge clk);
    fork
      drive_cases();
      check_cases();
    join
    repeat (2) @(posedge clk);
    exp_pulses = 0;
    foreach (cases[k]) begin
      if (!cases[k].flush) begin
        exp_pulses++;
      end
    end
    if (wb_count == exp_pulses) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Saw %0d write-back pulses for %0d instructions", wb_count, exp_pulses);
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

/* testbench/core_cases.txt */
# Columns, all hex: op rd rs1 rs2 imm flush exp_we exp_waddr exp_wdata exp_fault
# op: 0 add, 1 sub, 2 xor, 3 li, 4 lw, 5 sw
3 1 0 0 0005 0 1 1 00000005 0
3 2 0 0 FFFD 0 1 2 FFFFFFFD 0
0 3 1 2 0000 0 1 3 00000002 0
1 4 1 2 0000 0 1 4 00000008 0
2 5 1 2 0000 0 1 5 FFFFFFF8 0
3 0 0 0 1234 0 1 0 00001234 0
0 6 0 1 0000 0 1 6 00000005 0
5 0 1 4 0003 0 0 0 00000000 0
4 7 4 0 0000 0 1 7 00000008 0
0 3 3 3 0000 0 1 3 00000004 0
0 7 7 7 0000 0 1 7 00000010 0
5 0 0 2 001F 0 0 0 00000000 0
4 8 1 0 001A 0 1 8 FFFFFFFD 0
5 0 0 5 0020 0 0 0 00000000 1
4 7 2 0 0000 0 0 0 00000000 1
4 9 0 0 0000 0 1 9 00000000 0
0 A 7 0 0000 0 1 A 00000010 0
3 1 0 0 00AA 1 0 0 00000000 0
0 B 1 0 0000 0 1 B 00000005 0
4 6 4 0 0000 1 0 0 00000000 0
0 C 6 1 0000 0 1 C 0000000A 0
5 0 3 5 0000 0 0 0 00000000 0
4 D C 0 FFFA 0 1 D FFFFFFF8 0
1 E D 8 0000 0 1 E FFFFFFFB 0
2 F E A 0000 0 1 F FFFFFFEB 0

/* sources.f */
+incdir+src
src/core_pkg.sv
src/ctrl_fsm.sv
src/ex_unit.sv
src/lsu_unit.sv
src/wb_stage.sv
src/regfile.sv
src/core_top.sv
testbench/core_asserts.sv
testbench/tb_core.sv

/* Bender.yml */
package:
  name: core_exwb

sources:
  - include_dirs:
      - src
    files:
      - src/core_pkg.sv
      - src/ctrl_fsm.sv
      - src/ex_unit.sv
      - src/lsu_unit.sv
      - src/wb_stage.sv
      - src/regfile.sv
      - src/core_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/core_asserts.sv
      - testbench/tb_core.sv
